//--- common/aximm_settings.svh
/*
 * AXI-MM user loop settings
 * bus widths, memory depth and CSR register offsets
 */
`ifndef AXIMM_SETTINGS_SVH
`define AXIMM_SETTINGS_SVH

`define AXIMM_ADDR_W 32
`define AXIMM_DATA_W 64
`define AXIMM_ID_W 4
`define AXIMM_LEN_W 8
`define AXIMM_MEM_AW 8
`define AXIMM_CSR_W 32

// host port register map
`define AXIMM_REG_CTRL 32'h0000_0000
`define AXIMM_REG_LEN 32'h0000_0004
`define AXIMM_REG_ADDR 32'h0000_0008
`define AXIMM_REG_STAT 32'h0000_000C

`endif

//--- common/aximm_pkg.sv
/*
 * AXI-MM user loop types
 * channel payloads, host port types and the test pattern
 */
`include "aximm_settings.svh"
`default_nettype none

package aximm_pkg;

	localparam logic [2:0] AXI_SIZE_8B = 3'd3;
	localparam logic [1:0] AXI_BURST_INCR = 2'b01;
	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

	// AW and AR request
	typedef struct packed {
		logic [`AXIMM_ID_W-1:0] id;
		logic [`AXIMM_ADDR_W-1:0] addr;
		logic [`AXIMM_LEN_W-1:0] len;
		logic [2:0] size;
		logic [1:0] burst;
	} axi_addr_t;

	typedef struct packed {
		logic [`AXIMM_DATA_W-1:0] data;
		logic [`AXIMM_DATA_W/8-1:0] strb;
		logic last;
	} axi_w_t;

	typedef struct packed {
		logic [`AXIMM_ID_W-1:0] id;
		logic [`AXIMM_DATA_W-1:0] data;
		logic [1:0] resp;
		logic last;
	} axi_r_t;

	typedef struct packed {
		logic [`AXIMM_ID_W-1:0] id;
		logic [1:0] resp;
	} axi_b_t;

	typedef logic [`AXIMM_CSR_W-1:0] csr_addr_t;
	typedef logic [`AXIMM_CSR_W-1:0] csr_data_t;

	// bit 0 pass, bit 1 fail
	typedef struct packed {
		logic fail;
		logic pass;
	} test_done_t;

	typedef struct packed {
		logic [`AXIMM_ADDR_W-1:0] addr;
		logic [`AXIMM_LEN_W-1:0] len;
	} burst_cmd_t;

	// address in the upper half, its inverse below
	function automatic logic [`AXIMM_DATA_W-1:0] aximm_pattern(
		input logic [`AXIMM_ADDR_W-1:0] addr
	);
		return {addr, ~addr};
	endfunction

endpackage

`default_nettype wire

//--- verilog/aximm_chan_slice.sv
/*
 * Channel register slice
 * one-entry valid/ready stage for any payload type
 */
`timescale 1ns/1ps
`default_nettype none

module aximm_chan_slice #(
	parameter type T_PAYLOAD = logic
) (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic i_valid,
	input wire T_PAYLOAD i_data,
	output logic o_ready,
	output logic o_valid,
	output T_PAYLOAD o_data,
	input wire logic i_ready
);

	logic full;
	T_PAYLOAD data_q;

	// take a new item when empty or draining this cycle
	assign o_ready = !full || i_ready;
	assign o_valid = full;
	assign o_data = data_q;

	always_ff @(posedge i_clk) begin
		if (i_rst)
			full <= 1'b0;
		else if (o_ready)
			full <= i_valid;
	end

	always_ff @(posedge i_clk) begin
		if (i_valid && o_ready)
			data_q <= i_data;
	end

endmodule

`default_nettype wire

//--- verilog/aximm_link.sv
/*
 * AXI-MM channel link
 * one register slice per channel between leader and follower
 */
`timescale 1ns/1ps
`default_nettype none

module aximm_link (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic i_l_aw_valid,
	input wire aximm_pkg::axi_addr_t i_l_aw,
	output logic o_l_aw_ready,
	input wire logic i_l_w_valid,
	input wire aximm_pkg::axi_w_t i_l_w,
	output logic o_l_w_ready,
	input wire logic i_l_ar_valid,
	input wire aximm_pkg::axi_addr_t i_l_ar,
	output logic o_l_ar_ready,
	output logic o_l_r_valid,
	output aximm_pkg::axi_r_t o_l_r,
	input wire logic i_l_r_ready,
	output logic o_l_b_valid,
	output aximm_pkg::axi_b_t o_l_b,
	input wire logic i_l_b_ready,
	output logic o_f_aw_valid,
	output aximm_pkg::axi_addr_t o_f_aw,
	input wire logic i_f_aw_ready,
	output logic o_f_w_valid,
	output aximm_pkg::axi_w_t o_f_w,
	input wire logic i_f_w_ready,
	output logic o_f_ar_valid,
	output aximm_pkg::axi_addr_t o_f_ar,
	input wire logic i_f_ar_ready,
	input wire logic i_f_r_valid,
	input wire aximm_pkg::axi_r_t i_f_r,
	output logic o_f_r_ready,
	input wire logic i_f_b_valid,
	input wire aximm_pkg::axi_b_t i_f_b,
	output logic o_f_b_ready
);

	// leader to follower
	aximm_chan_slice #(.T_PAYLOAD(aximm_pkg::axi_addr_t)) u_aw (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_valid(i_l_aw_valid), .i_data(i_l_aw), .o_ready(o_l_aw_ready),
		.o_valid(o_f_aw_valid), .o_data(o_f_aw), .i_ready(i_f_aw_ready)
	);
	aximm_chan_slice #(.T_PAYLOAD(aximm_pkg::axi_w_t)) u_w (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_valid(i_l_w_valid), .i_data(i_l_w), .o_ready(o_l_w_ready),
		.o_valid(o_f_w_valid), .o_data(o_f_w), .i_ready(i_f_w_ready)
	);
	aximm_chan_slice #(.T_PAYLOAD(aximm_pkg::axi_addr_t)) u_ar (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_valid(i_l_ar_valid), .i_data(i_l_ar), .o_ready(o_l_ar_ready),
		.o_valid(o_f_ar_valid), .o_data(o_f_ar), .i_ready(i_f_ar_ready)
	);

	// follower to leader
	aximm_chan_slice #(.T_PAYLOAD(aximm_pkg::axi_r_t)) u_r (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_valid(i_f_r_valid), .i_data(i_f_r), .o_ready(o_f_r_ready),
		.o_valid(o_l_r_valid), .o_data(o_l_r), .i_ready(i_l_r_ready)
	);
	aximm_chan_slice #(.T_PAYLOAD(aximm_pkg::axi_b_t)) u_b (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_valid(i_f_b_valid), .i_data(i_f_b), .o_ready(o_f_b_ready),
		.o_valid(o_l_b_valid), .o_data(o_l_b), .i_ready(i_l_b_ready)
	);

endmodule

`default_nettype wire

//--- verilog/aximm_csr.sv
/*
 * AXI-MM loop control registers
 * host register port, burst start pulses and status readback
 */
`timescale 1ns/1ps
`include "aximm_settings.svh"
`default_nettype none

module aximm_csr (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire aximm_pkg::csr_addr_t i_wr_addr,
	input wire aximm_pkg::csr_data_t i_wrdata,
	input wire logic i_wren,
	input wire logic i_rden,
	output aximm_pkg::csr_data_t o_master_readdata,
	output logic o_master_readdatavalid,
	output logic o_master_waitrequest,
	input wire logic i_busy,
	input wire logic i_wr_complete,
	input wire logic i_rd_complete,
	input wire aximm_pkg::test_done_t i_test_done,
	output logic o_start_wr,
	output logic o_start_rd,
	output aximm_pkg::burst_cmd_t o_cmd
);

	logic [`AXIMM_LEN_W-1:0] len_q;
	aximm_pkg::csr_data_t addr_q;
	aximm_pkg::csr_data_t rd_mux;
	logic ctrl_sel;
	logic wr_acc;
	logic rd_acc;

	assign ctrl_sel = (i_wr_addr == `AXIMM_REG_CTRL);
	// a start already in flight counts as busy
	assign o_master_waitrequest = i_wren && ctrl_sel && (i_busy || o_start_wr || o_start_rd);
	assign wr_acc = i_wren && !o_master_waitrequest;
	assign rd_acc = i_rden && !o_master_waitrequest;
	assign o_cmd = '{addr: addr_q, len: len_q};

	always_comb begin
		case (i_wr_addr)
			`AXIMM_REG_LEN: rd_mux = aximm_pkg::csr_data_t'(len_q);
			`AXIMM_REG_ADDR: rd_mux = addr_q;
			`AXIMM_REG_STAT: rd_mux = aximm_pkg::csr_data_t'({i_busy, i_test_done,
				i_rd_complete, i_wr_complete});
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			len_q <= '0;
			addr_q <= '0;
			o_start_wr <= 1'b0;
			o_start_rd <= 1'b0;
			o_master_readdatavalid <= 1'b0;
		end else begin
			// write wins when both bits are set
			o_start_wr <= wr_acc && ctrl_sel && i_wrdata[0];
			o_start_rd <= wr_acc && ctrl_sel && i_wrdata[1] && !i_wrdata[0];
			o_master_readdatavalid <= rd_acc;
			if (wr_acc && i_wr_addr == `AXIMM_REG_LEN)
				len_q <= i_wrdata[`AXIMM_LEN_W-1:0];
			if (wr_acc && i_wr_addr == `AXIMM_REG_ADDR)
				addr_q <= i_wrdata;
		end
	end

	always_ff @(posedge i_clk) begin
		if (rd_acc)
			o_master_readdata <= rd_mux;
	end

endmodule

`default_nettype wire

//--- leader/aximm_leader_app.sv
/*
 * AXI-MM leader application
 * issues one write burst of pattern data or one read burst
 */
`timescale 1ns/1ps
`include "aximm_settings.svh"
`default_nettype none

module aximm_leader_app (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic i_start_wr,
	input wire logic i_start_rd,
	input wire aximm_pkg::burst_cmd_t i_cmd,
	output logic o_busy,
	output logic o_wr_complete,
	output logic o_rd_complete,
	output logic o_rbeat_valid,
	output aximm_pkg::axi_r_t o_rbeat,
	output logic o_aw_valid,
	output aximm_pkg::axi_addr_t o_aw,
	input wire logic i_aw_ready,
	output logic o_w_valid,
	output aximm_pkg::axi_w_t o_w,
	input wire logic i_w_ready,
	output logic o_ar_valid,
	output aximm_pkg::axi_addr_t o_ar,
	input wire logic i_ar_ready,
	input wire logic i_r_valid,
	input wire aximm_pkg::axi_r_t i_r,
	output logic o_r_ready,
	input wire logic i_b_valid,
	input wire aximm_pkg::axi_b_t i_b,
	output logic o_b_ready
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_WR_ADDR,
		S_WR_DATA,
		S_WR_RESP,
		S_RD_ADDR,
		S_RD_DATA
	} state_t;

	state_t state;
	aximm_pkg::burst_cmd_t cmd_q;
	aximm_pkg::axi_addr_t req;
	logic [`AXIMM_LEN_W-1:0] beat_cnt;
	logic [`AXIMM_ADDR_W-1:0] beat_addr;
	logic w_last;

	assign o_busy = (state != S_IDLE);
	assign o_r_ready = o_busy;
	assign o_b_ready = o_busy;
	assign o_rbeat_valid = i_r_valid && o_r_ready;
	assign o_rbeat = i_r;

	////////////////////////////////////////
	// request and write data
	assign req = '{id: '0, addr: cmd_q.addr, len: cmd_q.len,
		size: aximm_pkg::AXI_SIZE_8B, burst: aximm_pkg::AXI_BURST_INCR};
	assign o_aw = req;
	assign o_ar = req;
	assign o_aw_valid = (state == S_WR_ADDR);
	assign o_ar_valid = (state == S_RD_ADDR);

	assign w_last = (beat_cnt == cmd_q.len);
	assign o_w_valid = (state == S_WR_DATA);
	assign o_w = '{data: aximm_pkg::aximm_pattern(beat_addr), strb: '1, last: w_last};

	////////////////////////////////////////
	// burst FSM
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state <= S_IDLE;
			beat_cnt <= '0;
			o_wr_complete <= 1'b0;
			o_rd_complete <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (i_start_wr || i_start_rd) begin
						o_wr_complete <= 1'b0;
						o_rd_complete <= 1'b0;
					end
					if (i_start_wr)
						state <= S_WR_ADDR;
					else if (i_start_rd)
						state <= S_RD_ADDR;
				end
				S_WR_ADDR: begin
					if (i_aw_ready) begin
						state <= S_WR_DATA;
						beat_cnt <= '0;
					end
				end
				S_WR_DATA: begin
					if (i_w_ready) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (w_last)
							state <= S_WR_RESP;
					end
				end
				S_WR_RESP: begin
					if (i_b_valid) begin
						state <= S_IDLE;
						o_wr_complete <= (i_b.resp == aximm_pkg::AXI_RESP_OKAY);
					end
				end
				S_RD_ADDR: begin
					if (i_ar_ready)
						state <= S_RD_DATA;
				end
				S_RD_DATA: begin
					if (i_r_valid && i_r.last) begin
						state <= S_IDLE;
						o_rd_complete <= 1'b1;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// command follows the CSR block while idle
	always_ff @(posedge i_clk) begin
		if (state == S_IDLE) begin
			cmd_q <= i_cmd;
			beat_addr <= i_cmd.addr;
		end else if (o_w_valid && i_w_ready) begin
			beat_addr <= beat_addr + `AXIMM_ADDR_W'(8);
		end
	end

endmodule

`default_nettype wire

//--- follower/aximm_follower_app.sv
/*
 * AXI-MM follower application
 * stores write bursts in a 256 x 64 memory and returns them on reads
 */
`timescale 1ns/1ps
`include "aximm_settings.svh"
`default_nettype none

module aximm_follower_app (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic i_aw_valid,
	input wire aximm_pkg::axi_addr_t i_aw,
	output logic o_aw_ready,
	input wire logic i_w_valid,
	input wire aximm_pkg::axi_w_t i_w,
	output logic o_w_ready,
	input wire logic i_ar_valid,
	input wire aximm_pkg::axi_addr_t i_ar,
	output logic o_ar_ready,
	output logic o_r_valid,
	output aximm_pkg::axi_r_t o_r,
	input wire logic i_r_ready,
	output logic o_b_valid,
	output aximm_pkg::axi_b_t o_b,
	input wire logic i_b_ready
);

	typedef enum logic [1:0] {
		W_IDLE,
		W_DATA,
		W_RESP
	} wr_state_t;

	wr_state_t wr_state;
	logic [`AXIMM_DATA_W-1:0] mem [0:(1 << `AXIMM_MEM_AW)-1];
	logic [`AXIMM_MEM_AW-1:0] wr_idx;
	logic [`AXIMM_MEM_AW-1:0] rd_idx;
	logic [`AXIMM_LEN_W-1:0] rd_left;
	logic [`AXIMM_DATA_W-1:0] rd_data;
	logic rd_active;
	logic rd_adv;
	logic r_last;

	////////////////////////////////////////
	// write side
	assign o_aw_ready = (wr_state == W_IDLE);
	assign o_w_ready = (wr_state == W_DATA);
	assign o_b_valid = (wr_state == W_RESP);
	assign o_b = '{id: '0, resp: aximm_pkg::AXI_RESP_OKAY};

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			wr_state <= W_IDLE;
		end else begin
			case (wr_state)
				W_IDLE: if (i_aw_valid) wr_state <= W_DATA;
				W_DATA: if (i_w_valid && i_w.last) wr_state <= W_RESP;
				W_RESP: if (i_b_ready) wr_state <= W_IDLE;
				default: wr_state <= W_IDLE;
			endcase
		end
	end

	// beat index from address bits 10:3
	always_ff @(posedge i_clk) begin
		if (o_aw_ready && i_aw_valid) begin
			wr_idx <= i_aw.addr[3 +: `AXIMM_MEM_AW];
		end else if (o_w_ready && i_w_valid) begin
			for (int b = 0; b < `AXIMM_DATA_W/8; b++) begin
				if (i_w.strb[b])
					mem[wr_idx][b*8 +: 8] <= i_w.data[b*8 +: 8];
			end
			wr_idx <= wr_idx + 1'b1;
		end
	end

	////////////////////////////////////////
	// read side with one cycle memory latency
	assign o_ar_ready = !rd_active;
	// memory read stalls while an R beat waits
	assign rd_adv = !o_r_valid || i_r_ready;
	assign o_r = '{id: '0, data: rd_data, resp: aximm_pkg::AXI_RESP_OKAY, last: r_last};

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			rd_active <= 1'b0;
			o_r_valid <= 1'b0;
		end else begin
			if (i_ar_valid && o_ar_ready)
				rd_active <= 1'b1;
			else if (rd_adv && rd_active && rd_left == '0)
				rd_active <= 1'b0;
			if (rd_adv)
				o_r_valid <= rd_active;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_ar_valid && o_ar_ready) begin
			rd_idx <= i_ar.addr[3 +: `AXIMM_MEM_AW];
			rd_left <= i_ar.len;
		end else if (rd_adv && rd_active) begin
			rd_data <= mem[rd_idx];
			r_last <= (rd_left == '0);
			rd_idx <= rd_idx + 1'b1;
			rd_left <= rd_left - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- verilog/aximm_patchkr.sv
/*
 * Read pattern checker
 * compares returned beats with the address pattern, reports pass or fail
 */
`timescale 1ns/1ps
`include "aximm_settings.svh"
`default_nettype none

module aximm_patchkr (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic i_start_rd,
	input wire aximm_pkg::burst_cmd_t i_cmd,
	input wire logic i_rbeat_valid,
	input wire aximm_pkg::axi_r_t i_rbeat,
	output aximm_pkg::test_done_t o_test_done
);

	logic [`AXIMM_ADDR_W-1:0] exp_addr;
	logic [`AXIMM_LEN_W-1:0] exp_len;
	logic [`AXIMM_LEN_W-1:0] beat_cnt;
	logic mismatch;
	logic beat_bad;

	// data, response and last position all checked
	assign beat_bad = (i_rbeat.data != aximm_pkg::aximm_pattern(exp_addr))
		|| (i_rbeat.resp != aximm_pkg::AXI_RESP_OKAY)
		|| (i_rbeat.last != (beat_cnt == exp_len));

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			beat_cnt <= '0;
			mismatch <= 1'b0;
			o_test_done <= '0;
		end else if (i_start_rd) begin
			beat_cnt <= '0;
			mismatch <= 1'b0;
			o_test_done <= '0;
		end else if (i_rbeat_valid) begin
			beat_cnt <= beat_cnt + 1'b1;
			mismatch <= mismatch || beat_bad;
			if (i_rbeat.last) begin
				o_test_done.pass <= !(mismatch || beat_bad);
				o_test_done.fail <= mismatch || beat_bad;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_start_rd) begin
			exp_addr <= i_cmd.addr;
			exp_len <= i_cmd.len;
		end else if (i_rbeat_valid) begin
			exp_addr <= exp_addr + `AXIMM_ADDR_W'(8);
		end
	end

endmodule

`default_nettype wire

//--- verilog/aximm_aib_top.sv
/*
 * AXI-MM loop top level
 * CSR block, leader, channel link, follower and pattern checker
 */
`timescale 1ns/1ps
`default_nettype none

module aximm_aib_top (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire aximm_pkg::csr_addr_t i_wr_addr,
	input wire aximm_pkg::csr_data_t i_wrdata,
	input wire logic i_wren,
	input wire logic i_rden,
	output aximm_pkg::csr_data_t o_master_readdata,
	output logic o_master_readdatavalid,
	output logic o_master_waitrequest,
	output aximm_pkg::test_done_t o_test_done
);

	logic start_wr;
	logic start_rd;
	aximm_pkg::burst_cmd_t cmd;
	logic busy;
	logic wr_complete;
	logic rd_complete;
	logic rbeat_valid;
	aximm_pkg::axi_r_t rbeat;

	////////////////////////////////////////
	// leader side channels
	aximm_pkg::axi_addr_t l_aw;
	aximm_pkg::axi_addr_t l_ar;
	aximm_pkg::axi_w_t l_w;
	aximm_pkg::axi_r_t l_r;
	aximm_pkg::axi_b_t l_b;
	logic l_aw_valid;
	logic l_aw_ready;
	logic l_w_valid;
	logic l_w_ready;
	logic l_ar_valid;
	logic l_ar_ready;
	logic l_r_valid;
	logic l_r_ready;
	logic l_b_valid;
	logic l_b_ready;

	// follower side channels
	aximm_pkg::axi_addr_t f_aw;
	aximm_pkg::axi_addr_t f_ar;
	aximm_pkg::axi_w_t f_w;
	aximm_pkg::axi_r_t f_r;
	aximm_pkg::axi_b_t f_b;
	logic f_aw_valid;
	logic f_aw_ready;
	logic f_w_valid;
	logic f_w_ready;
	logic f_ar_valid;
	logic f_ar_ready;
	logic f_r_valid;
	logic f_r_ready;
	logic f_b_valid;
	logic f_b_ready;
	////////////////////////////////////////

	aximm_csr u_csr (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_wr_addr(i_wr_addr), .i_wrdata(i_wrdata), .i_wren(i_wren), .i_rden(i_rden),
		.o_master_readdata(o_master_readdata),
		.o_master_readdatavalid(o_master_readdatavalid),
		.o_master_waitrequest(o_master_waitrequest),
		.i_busy(busy), .i_wr_complete(wr_complete), .i_rd_complete(rd_complete),
		.i_test_done(o_test_done),
		.o_start_wr(start_wr), .o_start_rd(start_rd), .o_cmd(cmd)
	);

	aximm_leader_app u_leader (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_start_wr(start_wr), .i_start_rd(start_rd), .i_cmd(cmd),
		.o_busy(busy), .o_wr_complete(wr_complete), .o_rd_complete(rd_complete),
		.o_rbeat_valid(rbeat_valid), .o_rbeat(rbeat),
		.o_aw_valid(l_aw_valid), .o_aw(l_aw), .i_aw_ready(l_aw_ready),
		.o_w_valid(l_w_valid), .o_w(l_w), .i_w_ready(l_w_ready),
		.o_ar_valid(l_ar_valid), .o_ar(l_ar), .i_ar_ready(l_ar_ready),
		.i_r_valid(l_r_valid), .i_r(l_r), .o_r_ready(l_r_ready),
		.i_b_valid(l_b_valid), .i_b(l_b), .o_b_ready(l_b_ready)
	);

	aximm_link u_link (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_l_aw_valid(l_aw_valid), .i_l_aw(l_aw), .o_l_aw_ready(l_aw_ready),
		.i_l_w_valid(l_w_valid), .i_l_w(l_w), .o_l_w_ready(l_w_ready),
		.i_l_ar_valid(l_ar_valid), .i_l_ar(l_ar), .o_l_ar_ready(l_ar_ready),
		.o_l_r_valid(l_r_valid), .o_l_r(l_r), .i_l_r_ready(l_r_ready),
		.o_l_b_valid(l_b_valid), .o_l_b(l_b), .i_l_b_ready(l_b_ready),
		.o_f_aw_valid(f_aw_valid), .o_f_aw(f_aw), .i_f_aw_ready(f_aw_ready),
		.o_f_w_valid(f_w_valid), .o_f_w(f_w), .i_f_w_ready(f_w_ready),
		.o_f_ar_valid(f_ar_valid), .o_f_ar(f_ar), .i_f_ar_ready(f_ar_ready),
		.i_f_r_valid(f_r_valid), .i_f_r(f_r), .o_f_r_ready(f_r_ready),
		.i_f_b_valid(f_b_valid), .i_f_b(f_b), .o_f_b_ready(f_b_ready)
	);

	aximm_follower_app u_follower (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_aw_valid(f_aw_valid), .i_aw(f_aw), .o_aw_ready(f_aw_ready),
		.i_w_valid(f_w_valid), .i_w(f_w), .o_w_ready(f_w_ready),
		.i_ar_valid(f_ar_valid), .i_ar(f_ar), .o_ar_ready(f_ar_ready),
		.o_r_valid(f_r_valid), .o_r(f_r), .i_r_ready(f_r_ready),
		.o_b_valid(f_b_valid), .o_b(f_b), .i_b_ready(f_b_ready)
	);

	aximm_patchkr u_patchkr (
		.i_clk(i_clk), .i_rst(i_rst),
		.i_start_rd(start_rd), .i_cmd(cmd),
		.i_rbeat_valid(rbeat_valid), .i_rbeat(rbeat),
		.o_test_done(o_test_done)
	);

endmodule

`default_nettype wire

//--- verification/aximm_asserts.sv
/*
 * AXI-MM loop host port assertions
 * bound to the top level
 */
`timescale 1ns/1ps
`default_nettype none

module aximm_asserts (
	input wire logic i_clk,
	input wire logic i_rst,
	input wire logic i_wren,
	input wire logic i_rden,
	input wire logic i_readdatavalid,
	input wire logic i_waitrequest,
	input wire aximm_pkg::test_done_t i_test_done
);

	logic rd_acc;

	assign rd_acc = i_rden && !i_waitrequest;

	// read data valid exactly one cycle after acceptance
	a_rdv_after_read: assert property (@(posedge i_clk) disable iff (i_rst)
		rd_acc |=> i_readdatavalid)
		else $error("read data valid missing after an accepted read");
	a_rdv_only_after_read: assert property (@(posedge i_clk) disable iff (i_rst)
		!rd_acc |=> !i_readdatavalid)
		else $error("read data valid without an accepted read");

	a_done_exclusive: assert property (@(posedge i_clk) disable iff (i_rst)
		!(i_test_done.pass && i_test_done.fail))
		else $error("pass and fail high together");

	a_wait_needs_write: assert property (@(posedge i_clk) disable iff (i_rst)
		i_waitrequest |-> i_wren)
		else $error("waitrequest high without a write strobe");

endmodule

bind aximm_aib_top aximm_asserts u_asserts (
	.i_clk(i_clk),
	.i_rst(i_rst),
	.i_wren(i_wren),
	.i_rden(i_rden),
	.i_readdatavalid(o_master_readdatavalid),
	.i_waitrequest(o_master_waitrequest),
	.i_test_done(o_test_done)
);

`default_nettype wire

//--- verification/aximm_tb.sv
/*
 * AXI-MM loop testbench
 * runs the golden register script against the top level
 */
`timescale 1ns/1ps
`include "aximm_settings.svh"
`default_nettype none

module aximm_tb;

	localparam int WAIT_LIMIT = 2000;
	localparam int MEM_DEPTH = 1 << `AXIMM_MEM_AW;

	logic clk;
	logic rst;
	aximm_pkg::csr_addr_t wr_addr;
	aximm_pkg::csr_data_t wrdata;
	logic wren;
	logic rden;
	aximm_pkg::csr_data_t readdata;
	logic readdatavalid;
	logic waitrequest;
	aximm_pkg::test_done_t test_done;

	// reference copy of the follower memory
	logic [`AXIMM_DATA_W-1:0] model_mem [0:MEM_DEPTH-1];
	logic model_written [0:MEM_DEPTH-1];
	logic [`AXIMM_LEN_W-1:0] model_len;
	aximm_pkg::csr_data_t model_addr;
	aximm_pkg::test_done_t exp_done;
	aximm_pkg::test_done_t next_done;
	int value_errors;
	int run_errors;
	logic aborted;

	aximm_aib_top UUT (
		.i_clk(clk),
		.i_rst(rst),
		.i_wr_addr(wr_addr),
		.i_wrdata(wrdata),
		.i_wren(wren),
		.i_rden(rden),
		.o_master_readdata(readdata),
		.o_master_readdatavalid(readdatavalid),
		.o_master_waitrequest(waitrequest),
		.o_test_done(test_done)
	);

	always #4 clk = ~clk;

	// byte address in the upper half and its bitwise inverse in the lower half
	function automatic logic [`AXIMM_DATA_W-1:0] beat_pattern(
		input logic [`AXIMM_ADDR_W-1:0] addr
	);
		logic [`AXIMM_DATA_W-1:0] data;
		data[`AXIMM_DATA_W-1:`AXIMM_ADDR_W] = addr;
		data[`AXIMM_ADDR_W-1:0] = addr ^ {`AXIMM_ADDR_W{1'b1}};
		return data;
	endfunction

	////////////////////////////////////////
	// compare tasks
	task automatic check_csr(input string name, input aximm_pkg::csr_data_t got,
		input aximm_pkg::csr_data_t exp);
		if (got !== exp) begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_done(input aximm_pkg::test_done_t got,
		input aximm_pkg::test_done_t exp);
		if (got !== exp) begin
			$display("Fail o_test_done: got %h expected %h", got, exp);
			value_errors++;
		end
	endtask

	////////////////////////////////////////
	// host port accesses start and end on a falling edge
	task automatic csr_write(input aximm_pkg::csr_addr_t addr, input aximm_pkg::csr_data_t data);
		int waited;
		waited = 0;
		wr_addr = addr;
		wrdata = data;
		wren = 1'b1;
		// waitrequest settles shortly after the falling edge
		#1;
		while (!aborted && waitrequest) begin
			if (waited == WAIT_LIMIT) begin
				$display("timeout: write to offset %h held by waitrequest too long", addr);
				run_errors++;
				aborted = 1'b1;
			end else begin
				waited++;
				@(negedge clk);
				#1;
			end
		end
		@(posedge clk);
		@(negedge clk);
		wren = 1'b0;
	endtask

	task automatic csr_read(input aximm_pkg::csr_addr_t addr, output aximm_pkg::csr_data_t data);
		int waited;
		waited = 0;
		wr_addr = addr;
		rden = 1'b1;
		@(posedge clk);
		@(negedge clk);
		rden = 1'b0;
		while (!aborted && !readdatavalid) begin
			if (waited == WAIT_LIMIT) begin
				$display("timeout: no read data valid for offset %h", addr);
				run_errors++;
				aborted = 1'b1;
			end else begin
				waited++;
				@(negedge clk);
			end
		end
		data = readdata;
	endtask

	task automatic poll_stat(input aximm_pkg::csr_data_t val, input aximm_pkg::csr_data_t mask);
		aximm_pkg::csr_data_t rdata;
		int polls;
		polls = 0;
		csr_read(`AXIMM_REG_STAT, rdata);
		while (!aborted && (rdata & mask) != (val & mask)) begin
			if (polls == WAIT_LIMIT) begin
				$display("timeout: status never reached %h under mask %h", val, mask);
				run_errors++;
				aborted = 1'b1;
			end else begin
				polls++;
				csr_read(`AXIMM_REG_STAT, rdata);
			end
		end
	endtask

	// a write burst fills the model and a read burst predicts pass or fail
	task automatic model_ctrl(input aximm_pkg::csr_data_t val);
		logic [`AXIMM_MEM_AW-1:0] idx;
		logic [`AXIMM_ADDR_W-1:0] addr;
		logic ok;
		idx = model_addr[3 +: `AXIMM_MEM_AW];
		addr = model_addr;
		ok = 1'b1;
		for (int k = 0; k <= int'(model_len); k++) begin
			if (val[0]) begin
				model_mem[idx] = beat_pattern(addr);
				model_written[idx] = 1'b1;
			end else if (!model_written[idx] || model_mem[idx] != beat_pattern(addr)) begin
				ok = 1'b0;
			end
			idx = idx + 1'b1;
			addr = addr + 32'd8;
		end
		if (!val[0] && val[1]) begin
			exp_done = '0;
			next_done = '{fail: !ok, pass: ok};
		end
	endtask

	task automatic run_op(input logic [7:0] op, input aximm_pkg::csr_addr_t off,
		input aximm_pkg::csr_data_t val, input aximm_pkg::csr_data_t mask);
		aximm_pkg::csr_data_t rdata;
		case (op)
			"W": begin
				if (off == `AXIMM_REG_LEN)
					model_len = val[`AXIMM_LEN_W-1:0];
				if (off == `AXIMM_REG_ADDR)
					model_addr = val;
				csr_write(off, val);
				if (off == `AXIMM_REG_CTRL)
					model_ctrl(val);
			end
			"R": begin
				csr_read(off, rdata);
				if (!aborted)
					check_csr("o_master_readdata", rdata, val);
			end
			"P": begin
				poll_stat(val, mask);
				// result is final once read complete was seen
				if (mask[1] && val[1])
					exp_done = next_done;
				if (!aborted)
					check_done(test_done, exp_done);
			end
			default: begin
				$display("golden file holds an unknown operation %c", op);
				run_errors++;
			end
		endcase
	endtask

	initial begin
		int fd;
		int fields;
		string line;
		logic [7:0] op;
		aximm_pkg::csr_addr_t off;
		aximm_pkg::csr_data_t val;
		aximm_pkg::csr_data_t mask;
		clk = 1'b0;
		rst = 1'b1;
		wr_addr = '0;
		wrdata = '0;
		wren = 1'b0;
		rden = 1'b0;
		value_errors = 0;
		run_errors = 0;
		aborted = 1'b0;
		exp_done = '0;
		next_done = '0;
		model_len = '0;
		model_addr = '0;
		for (int i = 0; i < MEM_DEPTH; i++)
			model_written[i] = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		fd = $fopen("verification/aximm_golden.txt", "r");
		if (fd == 0) begin
			$display("could not open the golden file");
			run_errors++;
			aborted = 1'b1;
		end
		while (!aborted && !$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			fields = $sscanf(line, "%c %h %h %h", op, off, val, mask);
			if (fields == 4)
				run_op(op, off, val, mask);
		end
		if (fd != 0)
			$fclose(fd);

		$display("errors: value %0d, run %0d", value_errors, run_errors);
		if (value_errors == 0 && run_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/aximm_golden.txt
# op offset value mask, fields in hex; the mask is used by P only
# W writes, R reads and compares, P polls STAT until (STAT & mask) == (value & mask)
R 0C 00000000 00000000
P 0C 00000000 0000001F
W 04 0000000F 00000000
W 08 00000100 00000000
R 04 0000000F 00000000
R 08 00000100 00000000
W 00 00000001 00000000
P 0C 00000001 0000001F
W 00 00000002 00000000
P 0C 00000006 0000001F
W 04 000000FF 00000000
W 08 00000800 00000000
W 00 00000001 00000000
W 00 00000002 00000000
P 0C 00000006 0000001F
R 04 000000FF 00000000
R 08 00000800 00000000
W 04 00000003 00000000
W 08 00000200 00000000
W 00 00000001 00000000
P 0C 00000005 0000001F
W 08 00000208 00000000
W 00 00000002 00000000
P 0C 00000000 0000000E
P 0C 0000000A 0000001F
W 04 0000000F 00000000
W 08 00000900 00000000
W 00 00000002 00000000
P 0C 00000000 0000000E
P 0C 00000006 0000001F

//--- all.f
+incdir+common
common/aximm_pkg.sv
verilog/aximm_chan_slice.sv
verilog/aximm_link.sv
verilog/aximm_csr.sv
leader/aximm_leader_app.sv
follower/aximm_follower_app.sv
verilog/aximm_patchkr.sv
verilog/aximm_aib_top.sv
verification/aximm_asserts.sv
verification/aximm_tb.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the AXI-MM loop testbench
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module aximm_tb \
	-Mdir obj_dir -o aximm_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/aximm_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if grep -q "Done: errors found" "$LOG"; then
	exit 1
fi
exit 0
